/* bench/btac_properties.sv */
`timescale 1ns/1ps

module btac_properties (
  input logic        clock,
  input logic        reset,
  input logic [31:0] get_pc0,
  input logic [31:0] get_pc1,
  input logic        get_jal0,
  input logic        get_branch0,
  input logic        get_jal1,
  input logic        get_branch1,
  input logic        upd_jump0,
  input logic        upd_jump1,
  input logic        stall,
  input logic        clear,
  input logic        pred_branch,
  input logic [31:0] pred_baddr,
  input logic [31:0] pred_pc,
  input logic [31:0] pred_npc,
  input logic        pred_miss
);

  // Set by any fetch strobe and cleared by a miss, since a miss flushes the queue.
  logic fetched;

  always_ff @(posedge clock) begin
    if (!reset) begin
      fetched <= 1'b0;
    end else if (pred_miss) begin
      fetched <= 1'b0;
    end else if (get_jal0 || get_branch0 || get_jal1 || get_branch1) begin
      fetched <= 1'b1;
    end
  end

  quiet_outputs: assert property (@(posedge clock) (stall || clear) |->
      !pred_branch && pred_baddr == '0 && pred_pc == '0 && pred_npc == '0)
    else $error("Prediction outputs are not zero under stall or clear.");

  no_miss_after_reset: assert property (@(posedge clock) $rose(reset) |-> !pred_miss)
    else $error("Mispredict raised in the first cycle after reset.");

  // With nothing queued, a resolved jump was never predicted.
  unpredicted_jump_misses: assert property (@(posedge clock) disable iff (!reset)
      (upd_jump0 || upd_jump1) && !clear && !fetched |=> pred_miss)
    else $error("Unpredicted jump did not raise a mispredict.");

  hit_matches_fetch: assert property (@(posedge clock) disable iff (!reset)
      pred_branch |-> (pred_pc == $past(get_pc0)) || (pred_pc == $past(get_pc1)))
    else $error("Predicted pc matches neither fetch pc of the previous cycle.");

endmodule

bind btac btac_properties btac_props (
  .clock       (clock),
  .reset       (reset),
  .get_pc0     (get_pc0),
  .get_pc1     (get_pc1),
  .get_jal0    (get_jal0),
  .get_branch0 (get_branch0),
  .get_jal1    (get_jal1),
  .get_branch1 (get_branch1),
  .upd_jump0   (upd_jump0),
  .upd_jump1   (upd_jump1),
  .stall       (stall),
  .clear       (clear),
  .pred_branch (pred_branch),
  .pred_baddr  (pred_baddr),
  .pred_pc     (pred_pc),
  .pred_npc    (pred_npc),
  .pred_miss   (pred_miss)
);

/* bench/btac_tb.sv */
`timescale 1ns/1ps
`include "btac_defs.svh"

module btac_tb;

  logic        clock;
  logic        reset;
  logic [31:0] get_pc0;
  logic [31:0] get_pc1;
  logic        get_jal0;
  logic        get_branch0;
  logic        get_jal1;
  logic        get_branch1;
  logic [31:0] upd_pc0;
  logic [31:0] upd_npc0;
  logic [31:0] upd_addr0;
  logic        upd_jal0;
  logic        upd_branch0;
  logic        upd_jump0;
  logic [31:0] upd_pc1;
  logic [31:0] upd_npc1;
  logic [31:0] upd_addr1;
  logic        upd_jal1;
  logic        upd_branch1;
  logic        upd_jump1;
  logic        stall;
  logic        clear;
  logic        pred_branch;
  logic [31:0] pred_baddr;
  logic [31:0] pred_pc;
  logic [31:0] pred_npc;
  logic        pred_miss;
  logic [31:0] pred_maddr;
  logic        pred_hazard;

  int          value_errors;
  int          timeout_errors;
  logic [31:0] rnd_state;
  logic [31:0] pc_a;
  logic [31:0] pc_b;

  localparam logic [31:0] branch_pc = 32'h0000_1040;
  localparam logic [31:0] target_a  = 32'h0000_2000;
  localparam logic [31:0] target_b  = 32'h0000_3300;

  // Reference copy of the buffer, written by the same training rule.
  btac_pkg::target_entry_t model_table [0:`BTAC_BTB_DEPTH-1];

  btac uut (.*);

  always #50 clock = ~clock;

  // ************************************************************
  // Helpers
  // ************************************************************

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic step_cycle();
    @(posedge clock);
    #5;
  endtask

  task automatic note_failure(input string msg);
    value_errors++;
    $display("FAIL %0t: %s", $time, msg);
  endtask

  task automatic finish_run();
    $display("Errors: %0d wrong values, %0d timeouts", value_errors, timeout_errors);
    if (value_errors == 0 && timeout_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  endtask

  task automatic train_model(input logic [31:0] pc, input logic [31:0] dest,
                             input logic [31:0] next_pc);
    model_table[pc[`BTAC_BTB_INDEX+1:2]] = '{target: dest, pc: pc, npc: next_pc};
  endtask

  // Lookup rule: a non-zero entry whose tag is the fetch pc hits, slot 0 first.
  task automatic check_prediction(input logic [31:0] pc0, input logic [31:0] pc1);
    btac_pkg::target_entry_t e0;
    btac_pkg::target_entry_t e1;
    btac_pkg::target_entry_t exp_e;
    logic hit0;
    logic hit1;
    e0 = model_table[pc0[`BTAC_BTB_INDEX+1:2]];
    e1 = model_table[pc1[`BTAC_BTB_INDEX+1:2]];
    hit0 = (e0 != '0) && (e0.pc == pc0);
    hit1 = (e1 != '0) && (e1.pc == pc1);
    exp_e = '0;
    if (hit0) begin
      exp_e = e0;
    end else if (hit1) begin
      exp_e = e1;
    end
    assert (pred_branch == (hit0 || hit1)) else
      note_failure($sformatf("pred_branch %0b for pcs %h %h", pred_branch, pc0, pc1));
    assert ({pred_baddr, pred_pc, pred_npc} == exp_e) else
      note_failure($sformatf("prediction %h %h %h, expected %h",
                             pred_baddr, pred_pc, pred_npc, exp_e));
    assert (!pred_miss) else
      note_failure("pred_miss high during a plain fetch");
  endtask

  task automatic fetch_and_check(input logic [31:0] pc0, input logic [31:0] pc1);
    get_pc0 = pc0;
    get_pc1 = pc1;
    step_cycle();
    @(negedge clock);
    check_prediction(pc0, pc1);
    step_cycle();
  endtask

  // The strobe comes with the prediction, so the pushed record carries it.
  task automatic fetch_with_jal0(input logic [31:0] pc);
    get_pc0 = pc;
    step_cycle();
    get_jal0 = 1'b1;
    @(negedge clock);
    check_prediction(pc, get_pc1);
    step_cycle();
    get_jal0 = 1'b0;
  endtask

  task automatic wait_miss_clear();
    int count;
    count = 0;
    while (pred_miss && count < 10) begin
      step_cycle();
      count++;
    end
    if (pred_miss) begin
      timeout_errors++;
      $display("Timeout: pred_miss stayed high for %0d cycles", count);
    end
  endtask

  // A jump is resolved as a jal, otherwise as a branch that was not taken.
  task automatic resolve_slot0(input logic [31:0] pc, input logic [31:0] next_pc,
                               input logic [31:0] dest, input logic is_jump,
                               input logic exp_miss, input logic [31:0] exp_maddr);
    upd_pc0     = pc;
    upd_npc0    = next_pc;
    upd_addr0   = dest;
    upd_jal0    = is_jump;
    upd_branch0 = !is_jump;
    upd_jump0   = is_jump;
    @(negedge clock);
    assert (pred_hazard == exp_miss) else
      note_failure($sformatf("pred_hazard %0b, expected %0b", pred_hazard, exp_miss));
    step_cycle();
    upd_jal0    = 1'b0;
    upd_branch0 = 1'b0;
    upd_jump0   = 1'b0;
    @(negedge clock);
    assert (pred_miss == exp_miss) else
      note_failure($sformatf("pred_miss %0b, expected %0b", pred_miss, exp_miss));
    if (exp_miss) begin
      assert (pred_maddr == exp_maddr) else
        note_failure($sformatf("pred_maddr %h, expected %h", pred_maddr, exp_maddr));
    end
    if (is_jump) begin
      train_model(pc, dest, next_pc);
    end
    step_cycle();
    wait_miss_clear();
  endtask

  // ************************************************************
  // Stimulus
  // ************************************************************

  initial begin
    clock = 1'b0;
    reset = 1'b0;
    {get_pc0, get_pc1, get_jal0, get_branch0, get_jal1, get_branch1} = '0;
    {upd_pc0, upd_npc0, upd_addr0, upd_jal0, upd_branch0, upd_jump0} = '0;
    {upd_pc1, upd_npc1, upd_addr1, upd_jal1, upd_branch1, upd_jump1} = '0;
    stall = 1'b0;
    clear = 1'b0;
    value_errors = 0;
    timeout_errors = 0;
    rnd_state = 32'd6;
    for (int i = 0; i < `BTAC_BTB_DEPTH; i++) begin
      model_table[i] = '0;
    end
    repeat (3) @(posedge clock);
    #5;
    reset = 1'b1;

    // Untrained buffer.
    for (int i = 0; i < 12; i++) begin
      rnd_state = xorshift(rnd_state);
      pc_a = {rnd_state[31:2], 2'b00};
      rnd_state = xorshift(rnd_state);
      pc_b = {rnd_state[31:2], 2'b00};
      fetch_and_check(pc_a, pc_b);
    end

    // Unpredicted jump trains the entry, then both slots look it up.
    resolve_slot0(branch_pc, branch_pc + 32'd4, target_a, 1'b1, 1'b1, target_a);
    fetch_and_check(branch_pc, 32'h0000_0000);
    fetch_and_check(pc_a, branch_pc);
    fetch_and_check(branch_pc ^ 32'h0001_0000, 32'h0000_0000);

    // Correct prediction, then a wrong target.
    fetch_with_jal0(branch_pc);
    resolve_slot0(branch_pc, branch_pc + 32'd4, target_a, 1'b1, 1'b0, 32'h0);
    fetch_with_jal0(branch_pc);
    resolve_slot0(branch_pc, branch_pc + 32'd4, target_b, 1'b1, 1'b1, target_b);

    // Predicted taken but resolved not taken redirects to the recorded npc.
    fetch_with_jal0(branch_pc);
    resolve_slot0(branch_pc, branch_pc + 32'd4, target_b, 1'b0, 1'b1,
                  model_table[branch_pc[`BTAC_BTB_INDEX+1:2]].npc);

    get_pc0 = branch_pc;
    step_cycle();
    stall = 1'b1;
    @(negedge clock);
    assert (!pred_branch && pred_baddr == '0 && pred_pc == '0 && pred_npc == '0) else
      note_failure("prediction outputs not zero under stall");
    step_cycle();
    stall = 1'b0;
    clear = 1'b1;
    @(negedge clock);
    assert (!pred_branch && pred_baddr == '0 && pred_pc == '0 && pred_npc == '0) else
      note_failure("prediction outputs not zero under clear");
    step_cycle();
    clear = 1'b0;
    fetch_and_check(branch_pc, pc_b);

    finish_run();
  end

endmodule

/* compile.f */
+incdir+rtl
rtl/btac_pkg.sv
rtl/btb_array.sv
rtl/pred_queue.sv
rtl/btac_ctrl.sv
rtl/btac.sv
bench/btac_properties.sv
bench/btac_tb.sv

/* rtl/btac.sv */
`timescale 1ns/1ps
`include "btac_defs.svh"

module btac (
  input  logic        clock,
  input  logic        reset,
  input  logic [31:0] get_pc0,
  input  logic [31:0] get_pc1,
  input  logic        get_jal0,
  input  logic        get_branch0,
  input  logic        get_jal1,
  input  logic        get_branch1,
  input  logic [31:0] upd_pc0,
  input  logic [31:0] upd_npc0,
  input  logic [31:0] upd_addr0,
  input  logic        upd_jal0,
  input  logic        upd_branch0,
  input  logic        upd_jump0,
  input  logic [31:0] upd_pc1,
  input  logic [31:0] upd_npc1,
  input  logic [31:0] upd_addr1,
  input  logic        upd_jal1,
  input  logic        upd_branch1,
  input  logic        upd_jump1,
  input  logic        stall,
  input  logic        clear,
  output logic        pred_branch,
  output logic [31:0] pred_baddr,
  output logic [31:0] pred_pc,
  output logic [31:0] pred_npc,
  output logic        pred_miss,
  output logic [31:0] pred_maddr,
  output logic        pred_hazard
);

  // Buffer training and lookup.
  logic                       wen;
  logic [`BTAC_BTB_INDEX-1:0] waddr;
  btac_pkg::target_entry_t    wdata;
  logic [`BTAC_BTB_INDEX-1:0] raddr0;
  logic [`BTAC_BTB_INDEX-1:0] raddr1;
  btac_pkg::target_entry_t    rdata0;
  btac_pkg::target_entry_t    rdata1;

  // Prediction queue traffic.
  logic                       push;
  btac_pkg::pred_record_t     push_data;
  logic                       pop;
  logic                       flush;
  logic                       pop_valid;
  btac_pkg::pred_record_t     pop_data;

  btb_array btb_array_inst (.*);

  pred_queue pred_queue_inst (.*);

  btac_ctrl btac_ctrl_inst (.*);

endmodule

/* rtl/btac_ctrl.sv */
`timescale 1ns/1ps
`include "btac_defs.svh"

module btac_ctrl (
  input  logic                          clock,
  input  logic                          reset,
  // Fetch side.
  input  logic [31:0]                   get_pc0,
  input  logic [31:0]                   get_pc1,
  input  logic                          get_jal0,
  input  logic                          get_branch0,
  input  logic                          get_jal1,
  input  logic                          get_branch1,
  // Resolution side.
  input  logic [31:0]                   upd_pc0,
  input  logic [31:0]                   upd_npc0,
  input  logic [31:0]                   upd_addr0,
  input  logic                          upd_jal0,
  input  logic                          upd_branch0,
  input  logic                          upd_jump0,
  input  logic [31:0]                   upd_pc1,
  input  logic [31:0]                   upd_npc1,
  input  logic [31:0]                   upd_addr1,
  input  logic                          upd_jal1,
  input  logic                          upd_branch1,
  input  logic                          upd_jump1,
  input  logic                          stall,
  input  logic                          clear,
  output logic                          pred_branch,
  output logic [31:0]                   pred_baddr,
  output logic [31:0]                   pred_pc,
  output logic [31:0]                   pred_npc,
  output logic                          pred_miss,
  output logic [31:0]                   pred_maddr,
  output logic                          pred_hazard,
  // Branch target buffer.
  output logic                          wen,
  output logic [`BTAC_BTB_INDEX-1:0]    waddr,
  output btac_pkg::target_entry_t       wdata,
  output logic [`BTAC_BTB_INDEX-1:0]    raddr0,
  output logic [`BTAC_BTB_INDEX-1:0]    raddr1,
  input  btac_pkg::target_entry_t       rdata0,
  input  btac_pkg::target_entry_t       rdata1,
  // Prediction queue.
  output logic                          push,
  output btac_pkg::pred_record_t        push_data,
  output logic                          pop,
  output logic                          flush,
  input  logic                          pop_valid,
  input  btac_pkg::pred_record_t        pop_data
);

  logic [31:0]                pc0_q;
  logic [31:0]                pc1_q;
  logic [`BTAC_BTB_INDEX-1:0] raddr0_q;
  logic [`BTAC_BTB_INDEX-1:0] raddr1_q;
  logic                       hit0;
  logic                       hit1;

  logic                       train0;
  logic                       train1;
  logic                       wen_q;
  logic [`BTAC_BTB_INDEX-1:0] waddr_q;
  btac_pkg::target_entry_t    wdata_q;

  logic                       rec_taken_q;
  logic                       rec_taken_d;
  btac_pkg::target_entry_t    rec_q;
  btac_pkg::target_entry_t    rec_d;
  logic                       miss0_q;
  logic                       miss1_q;
  logic                       miss0_d;
  logic                       miss1_d;
  logic [31:0]                maddr_q;
  logic [31:0]                maddr_d;

  // ************************************************************
  // Lookup
  // ************************************************************

  // A clear freezes the lookup so the buffer keeps reading the old lines.
  assign raddr0 = clear ? raddr0_q : get_pc0[`BTAC_BTB_INDEX+1:2];
  assign raddr1 = clear ? raddr1_q : get_pc1[`BTAC_BTB_INDEX+1:2];

  always_ff @(posedge clock) begin
    if (!reset) begin
      pc0_q    <= '0;
      pc1_q    <= '0;
      raddr0_q <= '0;
      raddr1_q <= '0;
    end else if (!clear) begin
      pc0_q    <= get_pc0;
      pc1_q    <= get_pc1;
      raddr0_q <= raddr0;
      raddr1_q <= raddr1;
    end
  end

  assign hit0 = (|rdata0) && (rdata0.pc == pc0_q);
  assign hit1 = (|rdata1) && (rdata1.pc == pc1_q);

  // Slot 0 wins when both slots hit.
  always_comb begin
    pred_branch = 1'b0;
    pred_baddr  = '0;
    pred_pc     = '0;
    pred_npc    = '0;
    if (!stall && !clear) begin
      pred_branch = hit0 | hit1;
      if (hit0) begin
        pred_baddr = rdata0.target;
        pred_pc    = rdata0.pc;
        pred_npc   = rdata0.npc;
      end else if (hit1) begin
        pred_baddr = rdata1.target;
        pred_pc    = rdata1.pc;
        pred_npc   = rdata1.npc;
      end
    end
  end

  assign push      = get_jal0 | get_branch0 | get_jal1 | get_branch1;
  assign push_data = '{taken: pred_branch,
                       entry: '{target: pred_baddr, pc: pred_pc, npc: pred_npc}};

  // ************************************************************
  // Resolution
  // ************************************************************

  assign pop = upd_jal0 | upd_branch0 | upd_jal1 | upd_branch1;

  always_comb begin
    rec_taken_d = rec_taken_q;
    rec_d       = rec_q;
    miss0_d     = 1'b0;
    miss1_d     = 1'b0;
    maddr_d     = '0;
    if (pop_valid) begin
      rec_taken_d = pop_data.taken;
      rec_d       = pop_data.entry;
    end
    if (!clear) begin
      if (rec_taken_d && (upd_pc0 == rec_d.pc)) begin
        if (upd_jump0) begin
          maddr_d     = upd_addr0;
          miss0_d     = (upd_addr0 != rec_d.target);
          rec_taken_d = 1'b0;
        end else if (upd_branch0) begin
          maddr_d     = rec_d.npc;
          miss0_d     = 1'b1;
          rec_taken_d = 1'b0;
        end
      end else if (rec_taken_d && (upd_pc1 == rec_d.pc)) begin
        if (upd_jump1) begin
          maddr_d     = upd_addr1;
          miss1_d     = (upd_addr1 != rec_d.target);
          rec_taken_d = 1'b0;
        end else if (upd_branch1) begin
          maddr_d     = rec_d.npc;
          miss1_d     = 1'b1;
          rec_taken_d = 1'b0;
        end
      end else if (upd_jump0) begin
        // Nothing was predicted for this jump, so fetch went the wrong way.
        maddr_d = upd_addr0;
        miss0_d = 1'b1;
      end else if (upd_jump1) begin
        maddr_d = upd_addr1;
        miss1_d = 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      rec_taken_q <= 1'b0;
      miss0_q     <= 1'b0;
      miss1_q     <= 1'b0;
      maddr_q     <= '0;
    end else begin
      rec_taken_q <= rec_taken_d;
      miss0_q     <= miss0_d;
      miss1_q     <= miss1_d;
      maddr_q     <= maddr_d;
    end
  end

  always_ff @(posedge clock) begin
    rec_q <= rec_d;
  end

  assign pred_miss   = miss0_q | miss1_q;
  assign pred_maddr  = maddr_q;
  assign pred_hazard = miss0_d;
  assign flush       = miss0_q | miss1_q;

  // ************************************************************
  // Training
  // ************************************************************

  assign train0 = (upd_jal0 | upd_branch0) & upd_jump0;
  assign train1 = (upd_jal1 | upd_branch1) & upd_jump1;

  always_ff @(posedge clock) begin
    if (!reset) begin
      wen_q <= 1'b0;
    end else begin
      wen_q <= !clear && (train0 || train1);
    end
  end

  always_ff @(posedge clock) begin
    if (train0) begin
      waddr_q <= upd_pc0[`BTAC_BTB_INDEX+1:2];
      wdata_q <= '{target: upd_addr0, pc: upd_pc0, npc: upd_npc0};
    end else begin
      waddr_q <= upd_pc1[`BTAC_BTB_INDEX+1:2];
      wdata_q <= '{target: upd_addr1, pc: upd_pc1, npc: upd_npc1};
    end
  end

  assign wen   = wen_q;
  assign waddr = waddr_q;
  assign wdata = wdata_q;

endmodule

/* rtl/btac_defs.svh */
`ifndef BTAC_DEFS_SVH
`define BTAC_DEFS_SVH

// Branch target buffer geometry. The index is taken from pc bits starting at bit 2.
`define BTAC_BTB_DEPTH 64
`define BTAC_BTB_INDEX 6

// Prediction queue geometry.
`define BTAC_QUEUE_DEPTH 8
`define BTAC_QUEUE_PTR 3

`endif

/* rtl/btac_pkg.sv */
package btac_pkg;

  // ************************************************************
  // One buffer entry. An all-zero entry means the slot is empty.
  // ************************************************************

  typedef struct packed {
    logic [31:0] target;
    logic [31:0] pc;
    logic [31:0] npc;
  } target_entry_t;

  // ************************************************************
  // Prediction recorded for each fetched control-flow instruction.
  // ************************************************************

  // The taken bit is the pred_branch value seen when the record was pushed.
  typedef struct packed {
    logic          taken;
    target_entry_t entry;
  } pred_record_t;

endpackage

/* rtl/btb_array.sv */
`timescale 1ns/1ps
`include "btac_defs.svh"

module btb_array (
  input  logic                          clock,
  input  logic                          wen,
  input  logic [`BTAC_BTB_INDEX-1:0]    waddr,
  input  btac_pkg::target_entry_t       wdata,
  input  logic [`BTAC_BTB_INDEX-1:0]    raddr0,
  input  logic [`BTAC_BTB_INDEX-1:0]    raddr1,
  output btac_pkg::target_entry_t       rdata0,
  output btac_pkg::target_entry_t       rdata1
);

  // Entries start out empty so that no lookup hits before training.
  btac_pkg::target_entry_t entries [0:`BTAC_BTB_DEPTH-1] = '{default: '0};

  logic [`BTAC_BTB_INDEX-1:0] raddr0_q = '0;
  logic [`BTAC_BTB_INDEX-1:0] raddr1_q = '0;

  always_ff @(posedge clock) begin
    raddr0_q <= raddr0;
    raddr1_q <= raddr1;
    if (wen) begin
      entries[waddr] <= wdata;
    end
  end

  // Data follow the registered address, one cycle after it was presented.
  assign rdata0 = entries[raddr0_q];
  assign rdata1 = entries[raddr1_q];

endmodule

/* rtl/pred_queue.sv */
`timescale 1ns/1ps
`include "btac_defs.svh"

module pred_queue (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   push,
  input  btac_pkg::pred_record_t push_data,
  input  logic                   pop,
  input  logic                   flush,
  output logic                   pop_valid,
  output btac_pkg::pred_record_t pop_data
);

  localparam logic [`BTAC_QUEUE_PTR-1:0] last_slot = `BTAC_QUEUE_PTR'(`BTAC_QUEUE_DEPTH - 1);

  btac_pkg::pred_record_t records [0:`BTAC_QUEUE_DEPTH-1];

  logic [`BTAC_QUEUE_PTR-1:0] wptr;
  logic [`BTAC_QUEUE_PTR-1:0] rptr;
  logic                       wrap;

  logic full;
  logic empty;
  logic push_ok;
  logic pop_ok;
  logic wptr_wraps;
  logic rptr_wraps;

  // With equal pointers the wrap flag tells a full queue from an empty one.
  assign full  = (wptr == rptr) && wrap;
  assign empty = (wptr == rptr) && !wrap;

  assign push_ok = push && !full && !flush;
  assign pop_ok  = pop && !empty && !flush;

  assign wptr_wraps = push_ok && (wptr == last_slot);
  assign rptr_wraps = pop_ok && (rptr == last_slot);

  assign pop_valid = pop_ok;
  assign pop_data  = records[rptr];

  always_ff @(posedge clock) begin
    if (!reset) begin
      wptr <= '0;
      rptr <= '0;
      wrap <= 1'b0;
    end else if (flush) begin
      wptr <= '0;
      rptr <= '0;
      wrap <= 1'b0;
    end else begin
      if (push_ok) begin
        wptr <= wptr_wraps ? '0 : wptr + 1'b1;
      end
      if (pop_ok) begin
        rptr <= rptr_wraps ? '0 : rptr + 1'b1;
      end
      // The writer wrapping sets the flag, the reader wrapping clears it.
      wrap <= wrap ^ wptr_wraps ^ rptr_wraps;
    end
  end

  always_ff @(posedge clock) begin
    if (push_ok) begin
      records[wptr] <= push_data;
    end
  end

endmodule

/* run.sh */
#!/bin/sh
set -e

# Build the testbench with Verilator from the project root and run it.
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module btac_tb -o btac_sim -f compile.f
if ! ./obj_dir/btac_sim > sim.log 2>&1; then
  cat sim.log
  exit 1
fi
cat sim.log
if grep -q "Simulation finished: FAIL" sim.log; then
  exit 1
fi
exit 0
